// File: common/alu16_pkg.sv
package alu16_pkg;

    // PC codes 0xfb and 0xfc are absent and decode as NO_OP
    typedef enum logic [7:0] {
        NO_OP  = 8'h00,
        ADD    = 8'h01,
        SUB    = 8'h02,
        AND    = 8'h03,
        OR     = 8'h04,
        NOT    = 8'h05,
        XOR    = 8'h06,
        RAND   = 8'h07,
        ROR    = 8'h08,
        RXOR   = 8'h09,
        LSL    = 8'h0A,
        LSR    = 8'h0B,
        ASL    = 8'h0C,
        ASR    = 8'h0D,
        CSL    = 8'h0E,
        CSR    = 8'h0F,
        INC    = 8'h10,
        DEC    = 8'h11,
        PUSH   = 8'hF9,
        POP    = 8'hFA,
        MOV_RA = 8'hFD,
        MOV_AR = 8'hFE,
        MOV_RR = 8'hFF
    } alu_op_e;

    // R is source only, SS and SP are destination only
    typedef enum logic [3:0] {
        SEL_NONE = 4'd0,
        SEL_A    = 4'd1,
        SEL_B    = 4'd2,
        SEL_C    = 4'd3,
        SEL_D    = 4'd4,
        SEL_E    = 4'd5,
        SEL_F    = 4'd6,
        SEL_R    = 4'd7,
        SEL_SS   = 4'd8,
        SEL_SP   = 4'd9,
        SEL_IMM  = 4'd10
    } reg_sel_e;

    // last field lands on bit 0, so ovf is bit 0 and stk_err bit 3
    typedef struct packed {
        logic stk_err;
        logic carry;
        logic zero;
        logic ovf;
    } flags_t;

    typedef struct packed {
        reg_sel_e dst_sel;
        reg_sel_e src_sel;
        reg_sel_e opa_sel;
        reg_sel_e opb_sel;
        logic     alu_en;
        logic     push;
        logic     pop;
        logic     out_en;
    } ctrl_t;

    localparam int FLAG_OUT_W = 16;

endpackage

// File: hw/op_decode.sv
`timescale 1ns/1ps

module op_decode (
    input  alu16_pkg::alu_op_e  i_op_i,
    input  alu16_pkg::reg_sel_e i_sel1_i,
    input  alu16_pkg::reg_sel_e i_sel2_i,
    output alu16_pkg::ctrl_t    ctrl_o
);
    import alu16_pkg::*;

    always_comb begin
        ctrl_o = '0;
        case (i_op_i)
            // two-operand ops
            ADD, SUB, AND, OR, XOR: begin
                ctrl_o.opa_sel = i_sel1_i;
                ctrl_o.opb_sel = i_sel2_i;
                ctrl_o.alu_en  = 1'b1;
            end
            // single-operand ops leave operand b unselected
            NOT, RAND, ROR, RXOR,
            LSL, LSR, ASL, ASR, CSL, CSR,
            INC, DEC: begin
                ctrl_o.opa_sel = i_sel1_i;
                ctrl_o.alu_en  = 1'b1;
            end
            MOV_RA: begin
                ctrl_o.src_sel = i_sel1_i;
                ctrl_o.out_en  = 1'b1;
            end
            PUSH: begin
                ctrl_o.src_sel = i_sel1_i;
                ctrl_o.out_en  = 1'b1;
                ctrl_o.push    = 1'b1;
            end
            MOV_AR: begin
                ctrl_o.dst_sel = i_sel2_i;
                ctrl_o.src_sel = SEL_IMM;
            end
            MOV_RR: begin
                ctrl_o.dst_sel = i_sel2_i;
                ctrl_o.src_sel = i_sel1_i;
            end
            // memory word arrives on the data input in the same cycle
            POP: begin
                ctrl_o.dst_sel = i_sel1_i;
                ctrl_o.src_sel = SEL_IMM;
                ctrl_o.pop     = 1'b1;
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

endmodule

// File: hw/reg_bank.sv
`timescale 1ns/1ps

module reg_bank #(
    parameter int DATA_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  alu16_pkg::ctrl_t    ctrl_i,
    input  logic [DATA_W-1:0]   data_i,
    input  logic [DATA_W-1:0]   res_i,
    input  logic                res_we_i,
    output logic [DATA_W-1:0]   opa_o,
    output logic [DATA_W-1:0]   opb_o,
    output logic [DATA_W-1:0]   src_o
);
    import alu16_pkg::*;

    // general registers A..F, indexed by their selector code
    logic [DATA_W-1:0] gp_q [1:6];
    logic [DATA_W-1:0] r_q;

    function automatic logic [DATA_W-1:0] pick(input reg_sel_e sel);
        logic [DATA_W-1:0] word;
        word = '0;
        if (sel inside {[SEL_A:SEL_F]})
            word = gp_q[sel];
        else if (sel == SEL_R)
            word = r_q;
        else if (sel == SEL_IMM)
            word = data_i;
        return word;
    endfunction

    always_comb begin
        opa_o = pick(ctrl_i.opa_sel);
        opb_o = pick(ctrl_i.opb_sel);
        src_o = pick(ctrl_i.src_sel);
    end

    // SS and SP destinations are picked up by the stack block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i <= 6; i++) begin
                gp_q[i] <= '0;
            end
        end else if (ctrl_i.dst_sel inside {[SEL_A:SEL_F]}) begin
            gp_q[ctrl_i.dst_sel] <= src_o;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            r_q <= '0;
        else if (res_we_i)
            r_q <= res_i;
    end

endmodule

// File: hw/stack_ctrl.sv
`timescale 1ns/1ps

module stack_ctrl #(
    parameter int DATA_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  alu16_pkg::ctrl_t    ctrl_i,
    input  logic [DATA_W-1:0]   data_i,
    output logic [DATA_W-1:0]   addr_o,
    output logic                mem_we_o,
    output logic                mem_re_o,
    output logic                stk_err_o
);
    import alu16_pkg::*;

    logic [DATA_W-1:0] ss_q;
    logic [DATA_W-1:0] sp_q;
    logic [DATA_W-1:0] top_addr;
    logic              sp_full;
    logic              sp_empty;

    assign top_addr = ss_q + sp_q;
    assign sp_full  = &sp_q;
    assign sp_empty = (sp_q == '0);

    assign mem_we_o = ctrl_i.push;
    assign mem_re_o = ctrl_i.pop;

    // push writes at the free slot, pop reads the last written one
    always_comb begin
        if (ctrl_i.push)
            addr_o = top_addr;
        else if (ctrl_i.pop)
            addr_o = top_addr - 1'b1;
        else
            addr_o = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ss_q <= '0;
        else if (ctrl_i.dst_sel == SEL_SS)
            ss_q <= data_i;
    end

    // SP saturates at both ends instead of wrapping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sp_q <= '0;
        else if (ctrl_i.dst_sel == SEL_SP)
            sp_q <= data_i;
        else if (ctrl_i.push && !sp_full)
            sp_q <= sp_q + 1'b1;
        else if (ctrl_i.pop && !sp_empty)
            sp_q <= sp_q - 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            stk_err_o <= 1'b0;
        else if (ctrl_i.push)
            stk_err_o <= sp_full;
        else if (ctrl_i.pop)
            stk_err_o <= sp_empty;
    end

endmodule

// File: alu_exec/alu_exec.sv
`timescale 1ns/1ps

module alu_exec #(
    parameter int DATA_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alu_en_i,
    input  alu16_pkg::alu_op_e  op_i,
    input  logic [DATA_W-1:0]   opa_i,
    input  logic [DATA_W-1:0]   opb_i,
    output logic [DATA_W-1:0]   res_o,
    output logic                res_we_o,
    output logic                ovf_o,
    output logic                zero_o,
    output logic                carry_o
);
    import alu16_pkg::*;

    // bit DATA_W of calc is the carry out
    logic [DATA_W:0] calc;
    logic            calc_ovf;
    logic            a_msb;
    logic            b_msb;

    assign a_msb = opa_i[DATA_W-1];
    assign b_msb = opb_i[DATA_W-1];

    always_comb begin
        calc     = '0;
        calc_ovf = 1'b0;
        case (op_i)
            ADD: begin
                calc     = {1'b0, opa_i} + {1'b0, opb_i};
                calc_ovf = (a_msb == b_msb) && (calc[DATA_W-1] != a_msb);
            end
            // top bit is the borrow
            SUB: begin
                calc     = {1'b0, opa_i} - {1'b0, opb_i};
                calc_ovf = (a_msb != b_msb) && (calc[DATA_W-1] != a_msb);
            end
            AND:  calc = {1'b0, opa_i & opb_i};
            OR:   calc = {1'b0, opa_i | opb_i};
            NOT:  calc = {1'b0, ~opa_i};
            XOR:  calc = {1'b0, opa_i ^ opb_i};
            RAND: calc = {{DATA_W{1'b0}}, &opa_i};
            ROR:  calc = {{DATA_W{1'b0}}, |opa_i};
            RXOR: calc = {{DATA_W{1'b0}}, ^opa_i};
            // old top bit falls into carry
            LSL, ASL: calc = {opa_i, 1'b0};
            LSR:  calc = {2'b00, opa_i[DATA_W-1:1]};
            ASR:  calc = {1'b0, a_msb, opa_i[DATA_W-1:1]};
            CSL:  calc = {1'b0, opa_i[DATA_W-2:0], a_msb};
            CSR:  calc = {1'b0, opa_i[0], opa_i[DATA_W-1:1]};
            INC:  calc = {1'b0, opa_i + 1'b1};
            DEC:  calc = {1'b0, opa_i - 1'b1};
            default: begin
                calc     = '0;
                calc_ovf = 1'b0;
            end
        endcase
    end

    // R in the register bank captures res_o on the same edge as the flags below
    assign res_o    = calc[DATA_W-1:0];
    assign res_we_o = alu_en_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_o   <= 1'b0;
            zero_o  <= 1'b0;
            carry_o <= 1'b0;
        end else if (alu_en_i) begin
            ovf_o   <= calc_ovf;
            zero_o  <= (calc[DATA_W-1:0] == '0);
            carry_o <= calc[DATA_W];
        end
    end

endmodule

// File: hw/alu16_top.sv
`timescale 1ns/1ps

module alu16_top #(
    parameter int DATA_W = 16
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  alu16_pkg::alu_op_e                 i_op_i,
    input  alu16_pkg::reg_sel_e                i_sel1_i,
    input  alu16_pkg::reg_sel_e                i_sel2_i,
    input  logic [DATA_W-1:0]                  i_data_i,
    output logic [DATA_W-1:0]                  o_data_o,
    output logic                               o_data_valid_o,
    output logic [DATA_W-1:0]                  o_addr_o,
    output logic                               o_mem_we_o,
    output logic                               o_mem_re_o,
    output logic [alu16_pkg::FLAG_OUT_W-1:0]   o_flag_o
);
    import alu16_pkg::*;

    ctrl_t             ctrl;
    flags_t            flags;
    logic [DATA_W-1:0] opa;
    logic [DATA_W-1:0] opb;
    logic [DATA_W-1:0] src_word;
    logic [DATA_W-1:0] res;
    logic              res_we;
    logic              alu_ovf;
    logic              alu_zero;
    logic              alu_carry;
    logic              stk_err;

    op_decode i_op_decode (
        .i_op_i   (i_op_i),
        .i_sel1_i (i_sel1_i),
        .i_sel2_i (i_sel2_i),
        .ctrl_o   (ctrl)
    );

    reg_bank #(
        .DATA_W (DATA_W)
    ) i_reg_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl_i   (ctrl),
        .data_i   (i_data_i),
        .res_i    (res),
        .res_we_i (res_we),
        .opa_o    (opa),
        .opb_o    (opb),
        .src_o    (src_word)
    );

    stack_ctrl #(
        .DATA_W (DATA_W)
    ) i_stack_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl_i    (ctrl),
        .data_i    (i_data_i),
        .addr_o    (o_addr_o),
        .mem_we_o  (o_mem_we_o),
        .mem_re_o  (o_mem_re_o),
        .stk_err_o (stk_err)
    );

    alu_exec #(
        .DATA_W (DATA_W)
    ) i_alu_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .alu_en_i (ctrl.alu_en),
        .op_i     (i_op_i),
        .opa_i    (opa),
        .opb_i    (opb),
        .res_o    (res),
        .res_we_o (res_we),
        .ovf_o    (alu_ovf),
        .zero_o   (alu_zero),
        .carry_o  (alu_carry)
    );

    assign o_data_o       = src_word;
    assign o_data_valid_o = ctrl.out_en;

    assign flags    = '{stk_err: stk_err, carry: alu_carry, zero: alu_zero, ovf: alu_ovf};
    assign o_flag_o = {{(FLAG_OUT_W - $bits(flags_t)){1'b0}}, flags};

endmodule

// File: testbench/alu16_sva.sv
`timescale 1ns/1ps

module alu16_sva #(
    parameter int DATA_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  alu16_pkg::ctrl_t    ctrl_i,
    input  logic [DATA_W-1:0]   sp_i,
    input  logic                stk_err_i,
    input  logic                mem_we_i,
    input  logic                mem_re_i
);
    import alu16_pkg::*;

    // SP may only move on a push, a pop or a direct load
    logic sp_hold;

    assign sp_hold = !ctrl_i.push && !ctrl_i.pop && (ctrl_i.dst_sel != SEL_SP);

    mem_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_we_i && mem_re_i))
        else $error("memory write and read enables are high together");

    err_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !stk_err_i)
        else $error("stack error flag is set right after reset");

    sp_stable: assert property (@(posedge clk) disable iff (!rst_n) sp_hold |=> $stable(sp_i))
        else $error("stack pointer moved without a push, pop or load");

endmodule

bind stack_ctrl alu16_sva #(
    .DATA_W (DATA_W)
) i_alu16_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl_i    (ctrl_i),
    .sp_i      (sp_q),
    .stk_err_i (stk_err_o),
    .mem_we_i  (mem_we_o),
    .mem_re_i  (mem_re_o)
);

// File: testbench/tb_alu16.sv
`timescale 1ns/1ps

module tb_alu16;
    import alu16_pkg::*;

    localparam int    DATA_W     = 16;
    localparam int    CLK_PERIOD = 40;
    localparam int    MEM_WORDS  = 256;
    localparam string CASE_FILE  = "testbench/alu16_cases.txt";

    // check kinds in the case file
    localparam logic [3:0] KIND_DATA  = 4'd1;
    localparam logic [3:0] KIND_ADDR  = 4'd2;
    localparam logic [3:0] KIND_FLAG  = 4'd3;
    localparam logic [3:0] KIND_WDATA = 4'd4;

    logic              clk;
    logic              rst_n;
    alu_op_e           op_drv;
    reg_sel_e          sel1_drv;
    reg_sel_e          sel2_drv;
    logic [DATA_W-1:0] din_drv;
    logic [DATA_W-1:0] data_in;
    logic [DATA_W-1:0] o_data;
    logic              o_data_valid;
    logic [DATA_W-1:0] o_addr;
    logic              o_mem_we;
    logic              o_mem_re;
    logic [15:0]       o_flag;

    string             case_name [$];
    logic [7:0]        case_op   [$];
    logic [3:0]        case_sel1 [$];
    logic [3:0]        case_sel2 [$];
    logic [DATA_W-1:0] case_din  [$];
    logic [3:0]        case_kind [$];
    logic [DATA_W-1:0] case_exp  [$];
    bit                cases_loaded = 1'b0;

    // external stack memory that answers a pop in the same cycle
    logic [DATA_W-1:0] mem [0:MEM_WORDS-1];

    alu16_top #(
        .DATA_W (DATA_W)
    ) i_alu16_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_op_i         (op_drv),
        .i_sel1_i       (sel1_drv),
        .i_sel2_i       (sel2_drv),
        .i_data_i       (data_in),
        .o_data_o       (o_data),
        .o_data_valid_o (o_data_valid),
        .o_addr_o       (o_addr),
        .o_mem_we_o     (o_mem_we),
        .o_mem_re_o     (o_mem_re),
        .o_flag_o       (o_flag)
    );

    assign data_in = o_mem_re ? mem[o_addr[7:0]] : din_drv;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem[a] <= {~a[7:0], a[7:0]};
            end
        end else if (o_mem_we) begin
            mem[o_addr[7:0]] <= o_data;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_cases();
        int                fd;
        int                got;
        string             line;
        string             name;
        logic [7:0]        op;
        logic [3:0]        s1;
        logic [3:0]        s2;
        logic [DATA_W-1:0] din;
        logic [3:0]        kind;
        logic [DATA_W-1:0] exp_v;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("the case file %s could not be opened", CASE_FILE);
            $display("TEST FAIL");
            $fatal(1, "missing case file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 0 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%s %h %h %h %h %h %h",
                                  name, op, s1, s2, din, kind, exp_v);
                    if (got == 7) begin
                        case_name.push_back(name);
                        case_op.push_back(op);
                        case_sel1.push_back(s1);
                        case_sel2.push_back(s2);
                        case_din.push_back(din);
                        case_kind.push_back(kind);
                        case_exp.push_back(exp_v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // output valid and memory strobes follow the opcode class in every cycle
    task automatic check_strobes(input int idx);
        logic [7:0] op;
        logic       valid_exp;
        logic       we_exp;
        logic       re_exp;
        op        = case_op[idx];
        valid_exp = (op == MOV_RA) || (op == PUSH);
        we_exp    = (op == PUSH);
        re_exp    = (op == POP);
        check_value({case_name[idx], " valid"}, {15'b0, valid_exp}, {15'b0, o_data_valid});
        check_value({case_name[idx], " we"}, {15'b0, we_exp}, {15'b0, o_mem_we});
        check_value({case_name[idx], " re"}, {15'b0, re_exp}, {15'b0, o_mem_re});
    endtask

    // combinational outputs are read in the low half of the cycle
    task automatic check_case(input int idx);
        string name;
        name = case_name[idx];
        check_strobes(idx);
        case (case_kind[idx])
            KIND_DATA:  check_value(name, case_exp[idx], o_data);
            KIND_ADDR:  check_value(name, case_exp[idx], o_addr);
            KIND_FLAG:  check_value(name, case_exp[idx], o_flag);
            KIND_WDATA: check_value(name, case_exp[idx], o_data);
            default: begin
            end
        endcase
    endtask

    initial begin
        rst_n    = 1'b0;
        op_drv   = NO_OP;
        sel1_drv = SEL_NONE;
        sel2_drv = SEL_NONE;
        din_drv  = '0;
        load_cases();
        if (case_name.size() == 0) begin
            $display("the case file holds no usable cases");
            $display("TEST FAIL");
            $fatal(1, "empty case file");
        end
        cases_loaded = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < case_name.size(); i++) begin
            @(posedge clk);
            op_drv   <= alu_op_e'(case_op[i]);
            sel1_drv <= reg_sel_e'(case_sel1[i]);
            sel2_drv <= reg_sel_e'(case_sel2[i]);
            din_drv  <= case_din[i];
            @(negedge clk);
            check_case(i);
        end
        @(posedge clk);
        op_drv   <= NO_OP;
        sel1_drv <= SEL_NONE;
        sel2_drv <= SEL_NONE;
        @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

    initial begin
        int timeout_ns;
        wait (cases_loaded);
        timeout_ns = (case_name.size() + 20) * CLK_PERIOD;
        #(timeout_ns);
        $display("the run did not finish within %0d ns", timeout_ns);
        $display("TEST FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: alu16.f
common/alu16_pkg.sv
hw/op_decode.sv
hw/reg_bank.sv
hw/stack_ctrl.sv
alu_exec/alu_exec.sv
hw/alu16_top.sv
testbench/alu16_sva.sv
testbench/tb_alu16.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_alu16 \
    -f alu16.f -o sim_alu16 > build.log 2>&1 \
    && ./obj_dir/sim_alu16 > sim.log 2>&1
grep -qs "^TEST PASS$" sim.log && echo "alu16 simulation passed" \
    || { echo "alu16 simulation failed, see build.log and sim.log"; exit 1; }

// File: testbench/alu16_cases.txt
# name op sel1 sel2 din kind expected, every field after the name in hex
# kind 0 none, 1 data output, 2 stack address, 3 flag word, 4 memory write data
rst_flags     00 0 0 0000 3 0000
rst_a         fd 1 0 0000 1 0000
rst_b         fd 2 0 0000 1 0000
rst_c         fd 3 0 0000 1 0000
rst_d         fd 4 0 0000 1 0000
rst_e         fd 5 0 0000 1 0000
rst_f         fd 6 0 0000 1 0000
rst_r         fd 7 0 0000 1 0000
load_a        fe 0 1 7fff 0 0000
load_b        fe 0 2 0001 0 0000
load_c        fe 0 3 8000 0 0000
load_d        fe 0 4 ffff 0 0000
load_e        fe 0 5 0f0f 0 0000
copy_a_f      ff 1 6 0000 0 0000
read_a        fd 1 0 0000 1 7fff
read_b        fd 2 0 0000 1 0001
read_c        fd 3 0 0000 1 8000
read_d        fd 4 0 0000 1 ffff
read_e        fd 5 0 0000 1 0f0f
read_f        fd 6 0 0000 1 7fff
add_ovf       01 1 2 0000 0 0000
add_ovf_r     fd 7 0 0000 1 8000
add_ovf_fl    00 0 0 0000 3 0001
add_cy        01 3 4 0000 0 0000
add_cy_r      fd 7 0 0000 1 7fff
add_cy_fl     00 0 0 0000 3 0005
sub_bw        02 2 1 0000 0 0000
sub_bw_r      fd 7 0 0000 1 8002
sub_bw_fl     00 0 0 0000 3 0004
sub_zero      02 1 6 0000 0 0000
sub_zero_r    fd 7 0 0000 1 0000
sub_zero_fl   00 0 0 0000 3 0002
and_ed        03 5 4 0000 0 0000
and_ed_r      fd 7 0 0000 1 0f0f
or_bc         04 2 3 0000 0 0000
or_bc_r       fd 7 0 0000 1 8001
xor_ee        06 5 5 0000 0 0000
xor_ee_r      fd 7 0 0000 1 0000
xor_ee_fl     00 0 0 0000 3 0002
not_e         05 5 0 0000 0 0000
not_e_r       fd 7 0 0000 1 f0f0
rand_d        07 4 0 0000 0 0000
rand_d_r      fd 7 0 0000 1 0001
rxor_e        09 5 0 0000 0 0000
rxor_e_r      fd 7 0 0000 1 0000
ror_c         08 3 0 0000 0 0000
ror_c_r       fd 7 0 0000 1 0001
lsl_c         0a 3 0 0000 0 0000
lsl_c_r       fd 7 0 0000 1 0000
lsl_c_fl      00 0 0 0000 3 0006
lsr_c         0b 3 0 0000 0 0000
lsr_c_r       fd 7 0 0000 1 4000
asl_b         0c 2 0 0000 0 0000
asl_b_r       fd 7 0 0000 1 0002
asr_c         0d 3 0 0000 0 0000
asr_c_r       fd 7 0 0000 1 c000
csl_c         0e 3 0 0000 0 0000
csl_c_r       fd 7 0 0000 1 0001
inc_d         10 4 0 0000 0 0000
inc_d_r       fd 7 0 0000 1 0000
inc_d_fl      00 0 0 0000 3 0002
dec_c         11 3 0 0000 0 0000
dec_c_r       fd 7 0 0000 1 7fff
csr_b         0f 2 0 0000 0 0000
csr_b_r       fd 7 0 0000 1 8000
load_ss       fe 0 8 0040 0 0000
load_sp       fe 0 9 0003 0 0000
push_a_adr    f9 1 0 0000 2 0043
push_e_dat    f9 5 0 0000 4 0f0f
pop_b_adr     fa 2 0 0000 2 0044
pop_b_read    fd 2 0 0000 1 0f0f
pop_c_adr     fa 3 0 0000 2 0043
pop_c_read    fd 3 0 0000 1 7fff
stk_ok_fl     00 0 0 0000 3 0000
load_sp_top   fe 0 9 ffff 0 0000
push_full     f9 1 0 0000 2 003f
push_held     f9 1 0 0000 2 003f
full_fl       00 0 0 0000 3 0008
load_sp_mid   fe 0 9 0005 0 0000
push_clear    f9 2 0 0000 2 0045
clear_fl      00 0 0 0000 3 0000
load_sp_zero  fe 0 9 0000 0 0000
pop_empty     fa 4 0 0000 2 003f
empty_fl      00 0 0 0000 3 0008
